// ==== mips_id.f ====
+incdir+hdl
+incdir+tb
hdl/mips_id_pkg.sv
hdl/if_id_reg.sv
hdl/inst_decoder.sv
hdl/operand_fetch.sv
hdl/branch_unit.sv
hdl/id_stage.sv
tb/tb_id_stage.sv

// ==== Makefile ====
TOP  := tb_id_stage
SIM  := obj_dir/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): mips_id.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -f mips_id.f --top-module $(TOP)

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/id_stage_tests.svh ====
// ALU one-hot, bit order add sub slt sltu and nor or xor sll srl sra lui
localparam logic [11:0] alu_add  = 12'b1000_0000_0000;
localparam logic [11:0] alu_sub  = 12'b0100_0000_0000;
localparam logic [11:0] alu_sltu = 12'b0001_0000_0000;
localparam logic [11:0] alu_or   = 12'b0000_0010_0000;
localparam logic [11:0] alu_sll  = 12'b0000_0000_1000;
localparam logic [11:0] alu_sra  = 12'b0000_0000_0010;
localparam logic [11:0] alu_lui  = 12'b0000_0000_0001;

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [4:0] shamt,
                                      input logic [5:0] funct);
    return {`OP_SPECIAL, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
endfunction

// Zero, negative or positive with equal odds
function automatic logic [31:0] rand_operand();
    case ($urandom_range(2))
        0: return 32'd0;
        1: return $urandom() | 32'h8000_0000;
        default: return $urandom() & 32'h7fff_ffff;
    endcase
endfunction

task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
endtask

// One fetch through IF/ID, outputs sampled mid-cycle
task automatic issue(input logic [31:0] pc, input logic [31:0] word);
    if_to_id.valid = 1'b1;
    if_to_id.pc    = pc;
    inst_rdata     = word;
    next_cycle();
endtask

task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_write.we   = 1'b1;
    wb_write.addr = addr;
    wb_write.data = data;
    next_cycle();
    wb_write.we = 1'b0;
endtask

task automatic idle_check(input string name);
    check_eq({name, " valid"}, 0, 32'(id_to_ex.valid));
    check_eq({name, " rf_we"}, 0, 32'(id_to_ex.rf_we));
    check_eq({name, " mem_en"}, 0, 32'(id_to_ex.mem_en));
    check_eq({name, " mem_we"}, 0, 32'(id_to_ex.mem_we));
    check_eq({name, " taken"}, 0, 32'(br.taken));
    check_eq({name, " stall_req"}, 0, 32'(stall_req));
endtask

task automatic reset_bubble_test();
    logic [31:0] beq33;
    beq33       = enc_i(`OP_BEQ, 3, 3, 16'h0004);   // Always taken once valid
    inst_rdata  = beq33;
    ex_is_load  = 1'b1;
    ex_fwd.addr = 5'd3;
    rst         = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    idle_check("reset");
    issue(32'h0000_0100, beq33);
    check_eq("loaded valid", 1, 32'(id_to_ex.valid));
    check_eq("loaded taken", 1, 32'(br.taken));
    check_eq("loaded stall_req", 1, 32'(stall_req));
    stall = 2'b11;
    issue(32'h0000_0200, beq33);
    check_eq("hold pc", 32'h0000_0100, id_to_ex.pc);
    check_eq("hold valid", 1, 32'(id_to_ex.valid));
    stall.ex_hold = 1'b0;
    next_cycle();
    idle_check("bubble");
    stall      = '0;
    ex_is_load = 1'b0;
    ex_fwd     = '0;
endtask

// mem is {mem_en, mem_we, rf_from_mem}
task automatic decode_case(input string name, input logic [31:0] word, input logic [11:0] alu,
                           input logic [2:0] src1, input logic [3:0] src2, input logic we,
                           input logic [4:0] waddr, input logic [2:0] mem);
    issue(32'h0000_1000, word);
    check_eq({name, " inst"}, word, id_to_ex.inst);
    check_eq({name, " alu_op"}, 32'(alu), 32'(id_to_ex.alu_op));
    check_eq({name, " src1"}, 32'(src1), 32'(id_to_ex.src1));
    check_eq({name, " src2"}, 32'(src2), 32'(id_to_ex.src2));
    check_eq({name, " rf_we"}, 32'(we), 32'(id_to_ex.rf_we));
    check_eq({name, " rf_waddr"}, 32'(waddr), 32'(id_to_ex.rf_waddr));
    check_eq({name, " mem"}, 32'(mem),
             32'({id_to_ex.mem_en, id_to_ex.mem_we, id_to_ex.rf_from_mem}));
endtask

task automatic decode_test();
    decode_case("addu", enc_r(1, 2, 5, 0, `FN_ADDU), alu_add, 3'b100, 4'b1000, 1, 5, 3'b000);
    decode_case("sub", enc_r(3, 4, 7, 0, `FN_SUB), alu_sub, 3'b100, 4'b1000, 1, 7, 3'b000);
    decode_case("sll", enc_r(0, 3, 9, 4, `FN_SLL), alu_sll, 3'b001, 4'b1000, 1, 9, 3'b000);
    decode_case("srav", enc_r(2, 3, 10, 0, `FN_SRAV), alu_sra, 3'b100, 4'b1000, 1, 10, 3'b000);
    decode_case("addiu", enc_i(`OP_ADDIU, 1, 6, 16'hfff0), alu_add, 3'b100, 4'b0100, 1, 6,
                3'b000);
    decode_case("sltiu", enc_i(`OP_SLTIU, 2, 12, 16'h0040), alu_sltu, 3'b100, 4'b0100, 1, 12,
                3'b000);
    decode_case("ori", enc_i(`OP_ORI, 1, 13, 16'h8001), alu_or, 3'b100, 4'b0001, 1, 13, 3'b000);
    decode_case("lui", enc_i(`OP_LUI, 0, 8, 16'h1234), alu_lui, 3'b000, 4'b0100, 1, 8, 3'b000);
    decode_case("lw", enc_i(`OP_LW, 4, 11, 16'h0010), alu_add, 3'b100, 4'b0100, 1, 11, 3'b101);
    decode_case("sw", enc_i(`OP_SW, 4, 11, 16'h0010), alu_add, 3'b100, 4'b0100, 0, 0, 3'b110);
    decode_case("jal", enc_j(`OP_JAL, 26'h0123456), alu_add, 3'b010, 4'b0010, 1, 31, 3'b000);
    issue(32'h0000_1000, enc_r(1, 2, 5, 3, `FN_AND));   // Nonzero shamt is illegal
    check_eq("and shamt rf_we", 0, 32'(id_to_ex.rf_we));
endtask

task automatic regfile_test();
    int          addrs[4] = '{1, 5, 17, 31};
    logic [31:0] vals[4];
    for (int i = 0; i < 4; i++) begin
        vals[i] = $urandom();
        write_reg(5'(addrs[i]), vals[i]);
    end
    write_reg(0, $urandom());
    for (int i = 0; i < 4; i++) begin
        issue(32'h0000_2000, enc_r(5'(addrs[i]), 5'(addrs[(i + 1) % 4]), 1, 0, `FN_ADDU));
        check_eq($sformatf("regfile r%0d", addrs[i]), vals[i], id_to_ex.rs_val);
        check_eq($sformatf("regfile r%0d", addrs[(i + 1) % 4]), vals[(i + 1) % 4],
                 id_to_ex.rt_val);
    end
    issue(32'h0000_2000, enc_r(0, 0, 1, 0, `FN_ADDU));
    check_eq("regfile r0", 0, id_to_ex.rs_val);
endtask

task automatic bypass_test();
    logic [31:0] rf_val;
    logic [31:0] exp;
    rf_val = $urandom();
    write_reg(12, rf_val);
    ex_fwd  = '{we: 1'b0, addr: 5'd12, data: $urandom()};
    mem_fwd = '{we: 1'b0, addr: 5'd12, data: $urandom()};
    wb_fwd  = '{we: 1'b0, addr: 5'd12, data: $urandom()};
    for (int mask = 0; mask < 8; mask++) begin
        ex_fwd.we  = mask[2];
        mem_fwd.we = mask[1];
        wb_fwd.we  = mask[0];
        exp = mask[2] ? ex_fwd.data : mask[1] ? mem_fwd.data : mask[0] ? wb_fwd.data : rf_val;
        issue(32'h0000_3000, enc_r(12, 12, 1, 0, `FN_ADDU));
        check_eq($sformatf("bypass mask %0d rs", mask), exp, id_to_ex.rs_val);
        check_eq($sformatf("bypass mask %0d rt", mask), exp, id_to_ex.rt_val);
    end
    // All sources active but for another register
    ex_fwd.addr  = 5'd13;
    mem_fwd.addr = 5'd13;
    wb_fwd.addr  = 5'd13;
    ex_fwd.we    = 1'b1;
    mem_fwd.we   = 1'b1;
    wb_fwd.we    = 1'b1;
    issue(32'h0000_3000, enc_r(12, 12, 1, 0, `FN_ADDU));
    check_eq("bypass no match", rf_val, id_to_ex.rs_val);
    ex_fwd  = '0;
    mem_fwd = '0;
    wb_fwd  = '0;
endtask

task automatic branch_case(input string name, input logic [31:0] pc, input logic [31:0] word,
                           input logic taken, input logic [31:0] target);
    issue(pc, word);
    check_eq({name, " taken"}, 32'(taken), 32'(br.taken));
    if (taken) begin
        check_eq({name, " target"}, target, br.target);
    end
endtask

// rs comes from $2 through EX, rt from $3 through MEM
task automatic branch_test();
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] cond_tgt;
    logic [31:0] jump_tgt;
    logic [15:0] off;
    logic [25:0] idx;
    for (int n = 0; n < branch_rounds; n++) begin
        pc  = $urandom() & 32'hffff_fffc;
        off = 16'($urandom());
        idx = 26'($urandom());
        a   = rand_operand();
        b   = ($urandom_range(1) == 0) ? a : rand_operand();
        ex_fwd   = '{we: 1'b1, addr: 5'd2, data: a};
        mem_fwd  = '{we: 1'b1, addr: 5'd3, data: b};
        cond_tgt = pc + 32'd4 + (32'(signed'(off)) << 2);
        jump_tgt = ((pc + 32'd4) & 32'hf000_0000) | (32'(idx) << 2);
        branch_case("beq", pc, enc_i(`OP_BEQ, 2, 3, off), a == b, cond_tgt);
        branch_case("bne", pc, enc_i(`OP_BNE, 2, 3, off), a != b, cond_tgt);
        branch_case("bgez", pc, enc_i(`OP_REGIMM, 2, `RT_BGEZ, off), $signed(a) >= 0, cond_tgt);
        branch_case("bgtz", pc, enc_i(`OP_BGTZ, 2, 0, off), $signed(a) > 0, cond_tgt);
        branch_case("blez", pc, enc_i(`OP_BLEZ, 2, 0, off), $signed(a) <= 0, cond_tgt);
        branch_case("bltz", pc, enc_i(`OP_REGIMM, 2, `RT_BLTZ, off), $signed(a) < 0, cond_tgt);
        branch_case("j", pc, enc_j(`OP_J, idx), 1, jump_tgt);
        branch_case("jal", pc, enc_j(`OP_JAL, idx), 1, jump_tgt);
        check_eq("jal link reg", 31, 32'(id_to_ex.rf_waddr));
        branch_case("jr", pc, enc_r(2, 0, 0, 0, `FN_JR), 1, a);
    end
    ex_fwd  = '0;
    mem_fwd = '0;
endtask

task automatic load_use_case(input string name, input logic [31:0] word,
                             input logic [4:0] addr, input logic is_load, input logic exp);
    ex_is_load  = is_load;
    ex_fwd.addr = addr;
    issue(32'h0000_4000, word);
    check_eq(name, 32'(exp), 32'(stall_req));
endtask

task automatic load_use_test();
    logic [31:0] word;
    word = enc_r(4, 6, 1, 0, `FN_ADDU);
    load_use_case("load-use rs", word, 4, 1, 1);
    load_use_case("load-use rt", word, 6, 1, 1);
    load_use_case("load-use other reg", word, 7, 1, 0);
    load_use_case("no load in EX", word, 4, 0, 0);
    load_use_case("load to r0", enc_r(0, 6, 1, 0, `FN_ADDU), 0, 1, 0);
    ex_is_load = 1'b0;
    ex_fwd     = '0;
endtask

// ==== tb/tb_id_stage.sv ====
`include "mips_id_defines.svh"

module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int branch_rounds = 6;
    // reset+bubble, decode, regfile, bypass, branch, load-use
    localparam int budget_cycles = 11 + 12 + 10 + 10 + 9 * branch_rounds + 5;

    logic                  clk = 1'b0;
    logic                  rst;
    mips_id_pkg::if_id_t   if_to_id;
    mips_id_pkg::stall_t   stall;
    logic [31:0]           inst_rdata;
    mips_id_pkg::fwd_t     wb_write;
    mips_id_pkg::fwd_t     ex_fwd;
    mips_id_pkg::fwd_t     mem_fwd;
    mips_id_pkg::fwd_t     wb_fwd;
    logic                  ex_is_load;
    mips_id_pkg::ex_ctrl_t id_to_ex;
    mips_id_pkg::branch_t  br;
    logic                  stall_req;
    int                    errors = 0;
    int                    checks = 0;

    always #20 clk = ~clk;

    id_stage u_dut (
        .clk        (clk),
        .rst        (rst),
        .if_to_id   (if_to_id),
        .stall      (stall),
        .inst_rdata (inst_rdata),
        .wb_write   (wb_write),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .id_to_ex   (id_to_ex),
        .br         (br),
        .stall_req  (stall_req)
    );

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    `include "id_stage_tests.svh"

    initial begin : watchdog
        #((budget_cycles + 20) * 40);
        $display("Timeout: the tests did not finish within %0d cycles", budget_cycles + 20);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'ha291db12));
        rst        = 1'b1;
        if_to_id   = '0;
        stall      = '0;
        inst_rdata = '0;
        wb_write   = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;

        reset_bubble_test();
        decode_test();
        regfile_test();
        bypass_test();
        branch_test();
        load_use_test();

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/id_stage.sv ====
`include "mips_id_defines.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_id_pkg::if_id_t    if_to_id,
    input  mips_id_pkg::stall_t    stall,
    input  logic [`MIPS_XLEN-1:0]  inst_rdata,
    input  mips_id_pkg::fwd_t      wb_write,
    input  mips_id_pkg::fwd_t      ex_fwd,
    input  mips_id_pkg::fwd_t      mem_fwd,
    input  mips_id_pkg::fwd_t      wb_fwd,
    input  logic                   ex_is_load,
    output mips_id_pkg::ex_ctrl_t  id_to_ex,
    output mips_id_pkg::branch_t   br,
    output logic                   stall_req
);

    mips_id_pkg::if_id_t     id_reg;
    mips_id_pkg::inst_u      id_inst;
    mips_id_pkg::ex_ctrl_t   dec_ctrl;
    mips_id_pkg::br_class_t  br_class;
    logic [`MIPS_XLEN-1:0]   id_pc;
    logic                    id_valid;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_XLEN-1:0]   rs_val;
    logic [`MIPS_XLEN-1:0]   rt_val;

    assign id_pc    = id_reg.pc;
    assign id_valid = id_reg.valid;
    assign id_inst  = inst_rdata;      // SRAM word lines up with the IF/ID PC

    if_id_reg u_if_id (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .if_to_id (if_to_id),
        .id_out   (id_reg)
    );

    inst_decoder u_dec (
        .inst     (id_inst),
        .valid    (id_valid),
        .ctrl     (dec_ctrl),
        .br_class (br_class),
        .rs       (rs),
        .rt       (rt)
    );

    operand_fetch u_opf (
        .clk        (clk),
        .rst        (rst),
        .rs         (rs),
        .rt         (rt),
        .valid      (id_valid),
        .wb_write   (wb_write),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .stall_req  (stall_req)
    );

    branch_unit u_br (
        .pc       (id_pc),
        .inst     (id_inst),
        .br_class (br_class),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .br       (br)
    );

    always_comb begin
        id_to_ex        = dec_ctrl;
        id_to_ex.pc     = id_pc;
        id_to_ex.rs_val = rs_val;
        id_to_ex.rt_val = rt_val;
    end

endmodule

// ==== hdl/branch_unit.sv ====
`include "mips_id_defines.svh"

module branch_unit (
    input  logic [`MIPS_XLEN-1:0]  pc,
    input  mips_id_pkg::inst_u     inst,
    input  mips_id_pkg::br_class_t br_class,
    input  logic [`MIPS_XLEN-1:0]  rs_val,
    input  logic [`MIPS_XLEN-1:0]  rt_val,
    output mips_id_pkg::branch_t   br
);

    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] cond_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [25:0]           jidx;
    logic                  rs_eq_rt;
    logic                  rs_neg;
    logic                  rs_zero;

    assign pc_plus4    = pc + `MIPS_XLEN'd4;
    assign cond_target = pc_plus4 + {{14{inst.i.imm16[15]}}, inst.i.imm16, 2'b00};
    assign jidx        = {inst.i.rs, inst.i.rt, inst.i.imm16};
    assign jump_target = {pc_plus4[31:28], jidx, 2'b00}; // Stays in the 256 MB region

    assign rs_eq_rt = rs_val == rt_val;
    assign rs_neg   = rs_val[`MIPS_XLEN-1];
    assign rs_zero  = rs_val == '0;

    always_comb begin
        br.taken  = 1'b0;
        br.target = cond_target;
        case (br_class)
            mips_id_pkg::beq:  br.taken = rs_eq_rt;
            mips_id_pkg::bne:  br.taken = !rs_eq_rt;
            mips_id_pkg::bgez: br.taken = !rs_neg;
            mips_id_pkg::bgtz: br.taken = !rs_neg && !rs_zero;
            mips_id_pkg::blez: br.taken = rs_neg || rs_zero;
            mips_id_pkg::bltz: br.taken = rs_neg;
            mips_id_pkg::jump_imm: begin
                br.taken  = 1'b1;
                br.target = jump_target;
            end
            mips_id_pkg::jump_reg: begin
                br.taken  = 1'b1;
                br.target = rs_val;
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/operand_fetch.sv ====
`include "mips_id_defines.svh"

module operand_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`MIPS_REG_AW-1:0] rs,
    input  logic [`MIPS_REG_AW-1:0] rt,
    input  logic                    valid,
    input  mips_id_pkg::fwd_t       wb_write,
    input  mips_id_pkg::fwd_t       ex_fwd,
    input  mips_id_pkg::fwd_t       mem_fwd,
    input  mips_id_pkg::fwd_t       wb_fwd,
    input  logic                    ex_is_load,
    output logic [`MIPS_XLEN-1:0]   rs_val,
    output logic [`MIPS_XLEN-1:0]   rt_val,
    output logic                    stall_req
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    // Youngest producer wins, register file last
    function automatic logic [`MIPS_XLEN-1:0] pick(
        input logic [`MIPS_REG_AW-1:0] addr,
        input logic [`MIPS_XLEN-1:0]   rf_val,
        input mips_id_pkg::fwd_t       ex,
        input mips_id_pkg::fwd_t       mem,
        input mips_id_pkg::fwd_t       wb
    );
        if (addr == '0) begin
            return '0;                 // $zero
        end
        if (ex.we && ex.addr == addr) begin
            return ex.data;
        end
        if (mem.we && mem.addr == addr) begin
            return mem.data;
        end
        if (wb.we && wb.addr == addr) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst && wb_write.we && wb_write.addr != '0) begin // Entry 0 never written
            regs[wb_write.addr] <= wb_write.data;
        end
    end

    assign rs_val = pick(rs, regs[rs], ex_fwd, mem_fwd, wb_fwd);
    assign rt_val = pick(rt, regs[rt], ex_fwd, mem_fwd, wb_fwd);

    // Load data is not ready until MEM, so a dependent instruction waits
    assign stall_req = valid && ex_is_load && ex_fwd.addr != '0 &&
                       (ex_fwd.addr == rs || ex_fwd.addr == rt);

endmodule

// ==== hdl/inst_decoder.sv ====
`include "mips_id_defines.svh"

module inst_decoder (
    input  mips_id_pkg::inst_u      inst,
    input  logic                    valid,
    output mips_id_pkg::ex_ctrl_t   ctrl,
    output mips_id_pkg::br_class_t  br_class,
    output logic [`MIPS_REG_AW-1:0] rs,
    output logic [`MIPS_REG_AW-1:0] rt
);

    assign rs = inst.r.rs;
    assign rt = inst.r.rt;

    always_comb begin : decode
        mips_id_pkg::alu_op_t alu;
        logic imm_shift;
        logic k_rrr, k_shamt, k_link_rd, k_link_ra;
        logic k_imm_s, k_imm_z, k_lui, k_load, k_store;

        alu       = '0;
        imm_shift = 1'b0;
        k_rrr     = 1'b0;
        k_shamt   = 1'b0;
        k_link_rd = 1'b0;
        k_link_ra = 1'b0;
        k_imm_s   = 1'b0;
        k_imm_z   = 1'b0;
        k_lui     = 1'b0;
        k_load    = 1'b0;
        k_store   = 1'b0;
        br_class  = mips_id_pkg::none;
        ctrl      = '0;               // pc and operands are filled in by the stage
        ctrl.valid = valid;
        ctrl.inst  = inst;

        if (valid) begin
            case (inst.i.opcode)
                `OP_SPECIAL: begin
                    case (inst.r.funct)
                        `FN_ADD, `FN_ADDU:  alu.add  = 1'b1;
                        `FN_SUB, `FN_SUBU:  alu.sub  = 1'b1;
                        `FN_SLT:            alu.slt  = 1'b1;
                        `FN_SLTU:           alu.sltu = 1'b1;
                        `FN_AND:            alu.and_ = 1'b1;
                        `FN_OR:             alu.or_  = 1'b1;
                        `FN_XOR:            alu.xor_ = 1'b1;
                        `FN_NOR:            alu.nor_ = 1'b1;
                        `FN_SLL, `FN_SLLV:  alu.sll  = 1'b1;
                        `FN_SRL, `FN_SRLV:  alu.srl  = 1'b1;
                        `FN_SRA, `FN_SRAV:  alu.sra  = 1'b1;
                        default: ;
                    endcase
                    imm_shift = inst.r.funct inside {`FN_SLL, `FN_SRL, `FN_SRA};
                    k_shamt   = (|alu) && imm_shift && inst.r.rs == '0;
                    k_rrr     = (|alu) && !imm_shift && inst.r.shamt == '0;
                    k_link_rd = inst.r.funct == `FN_JALR && inst.r.rt == '0 &&
                                inst.r.shamt == '0;
                    if (k_link_rd || (inst.r.funct == `FN_JR && inst.r.rt == '0 &&
                                      inst.r.rd == '0 && inst.r.shamt == '0)) begin
                        br_class = mips_id_pkg::jump_reg;
                    end
                end
                `OP_ADDI, `OP_ADDIU: begin
                    alu.add = 1'b1;
                    k_imm_s = 1'b1;
                end
                `OP_SLTI: begin
                    alu.slt = 1'b1;
                    k_imm_s = 1'b1;
                end
                `OP_SLTIU: begin
                    alu.sltu = 1'b1;        // Compare against sign-extended imm
                    k_imm_s  = 1'b1;
                end
                `OP_ANDI: begin
                    alu.and_ = 1'b1;
                    k_imm_z  = 1'b1;
                end
                `OP_ORI: begin
                    alu.or_ = 1'b1;
                    k_imm_z = 1'b1;
                end
                `OP_XORI: begin
                    alu.xor_ = 1'b1;
                    k_imm_z  = 1'b1;
                end
                `OP_LUI: begin
                    alu.lui = 1'b1;
                    k_lui   = inst.i.rs == '0;
                end
                `OP_LW:   k_load  = 1'b1;
                `OP_SW:   k_store = 1'b1;
                `OP_J:    br_class = mips_id_pkg::jump_imm;
                `OP_JAL: begin
                    br_class  = mips_id_pkg::jump_imm;
                    k_link_ra = 1'b1;
                end
                `OP_BEQ:  br_class = mips_id_pkg::beq;
                `OP_BNE:  br_class = mips_id_pkg::bne;
                `OP_BGTZ: if (inst.i.rt == '0) br_class = mips_id_pkg::bgtz;
                `OP_BLEZ: if (inst.i.rt == '0) br_class = mips_id_pkg::blez;
                `OP_REGIMM: begin
                    case (inst.i.rt)
                        `RT_BLTZ:   br_class = mips_id_pkg::bltz;
                        `RT_BGEZ:   br_class = mips_id_pkg::bgez;
                        `RT_BLTZAL: br_class = mips_id_pkg::bltz;
                        `RT_BGEZAL: br_class = mips_id_pkg::bgez;
                        default: ;
                    endcase
                    k_link_ra = inst.i.rt inside {`RT_BLTZAL, `RT_BGEZAL};
                end
                default: ;
            endcase
        end

        alu.add = alu.add | k_load | k_store | k_link_rd | k_link_ra; // Address or PC+8

        ctrl.src1.rs       = k_rrr | k_imm_s | k_imm_z | k_load | k_store;
        ctrl.src1.pc       = k_link_rd | k_link_ra;
        ctrl.src1.shamt    = k_shamt;
        ctrl.src2.rt       = k_rrr | k_shamt;
        ctrl.src2.imm_sext = k_imm_s | k_lui | k_load | k_store;
        ctrl.src2.const8   = k_link_rd | k_link_ra;
        ctrl.src2.imm_zext = k_imm_z;
        ctrl.mem_en        = k_load | k_store;
        ctrl.mem_we        = k_store;
        ctrl.rf_from_mem   = k_load;
        ctrl.rf_we         = k_rrr | k_shamt | k_imm_s | k_imm_z | k_lui | k_load |
                             k_link_rd | k_link_ra;

        if (k_link_ra) begin
            ctrl.rf_waddr = `MIPS_RA_REG;
        end else if (k_rrr || k_shamt || k_link_rd) begin
            ctrl.rf_waddr = inst.r.rd;
        end else if (ctrl.rf_we) begin
            ctrl.rf_waddr = inst.i.rt;
        end

        // Illegal encodings leave no stray ALU bit behind
        ctrl.alu_op = (ctrl.rf_we || ctrl.mem_en) ? alu : {`ALU_OP_W{1'b0}};
    end

endmodule

// ==== hdl/if_id_reg.sv ====
`include "mips_id_defines.svh"

module if_id_reg (
    input  logic                clk,
    input  logic                rst,
    input  mips_id_pkg::stall_t stall,
    input  mips_id_pkg::if_id_t if_to_id,
    output mips_id_pkg::if_id_t id_out
);

    // id_hold low loads the next fetch. With only id_hold set, ID empties
    // while EX keeps moving, so a bubble goes in. Both set freezes the slot.
    always_ff @(posedge clk) begin
        if (rst) begin
            id_out <= '0;
        end else if (!stall.id_hold) begin
            id_out <= if_to_id;
        end else if (!stall.ex_hold) begin
            id_out <= '0;              // Bubble
        end
    end

endmodule

// ==== hdl/mips_id_pkg.sv ====
`include "mips_id_defines.svh"

package mips_id_pkg;

    // Register-form view of the instruction word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } inst_r_t;

    // Immediate-form view, also holds the jump index
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [15:0]             imm16;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        logic id_hold;
        logic ex_hold;
    } stall_t;

    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_;
        logic nor_;
        logic or_;
        logic xor_;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    typedef struct packed {
        logic rs;
        logic pc;
        logic shamt;
    } src1_sel_t;

    typedef struct packed {
        logic rt;
        logic imm_sext;
        logic const8;                  // Link value is PC+8
        logic imm_zext;
    } src2_sel_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   inst;
        alu_op_t                 alu_op;
        src1_sel_t               src1;
        src2_sel_t               src2;
        logic                    mem_en;
        logic                    mem_we;
        logic                    rf_we;
        logic [`MIPS_REG_AW-1:0] rf_waddr;
        logic                    rf_from_mem;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
    } ex_ctrl_t;

    typedef enum logic [3:0] {
        none, beq, bne, bgez, bgtz, blez, bltz, jump_imm, jump_reg
    } br_class_t;

    // Bypass source or register-file write port
    typedef struct packed {
        logic                    we;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_XLEN-1:0]   data;
    } fwd_t;

    typedef struct packed {
        logic                  taken;
        logic [`MIPS_XLEN-1:0] target;
    } branch_t;

endpackage

// ==== hdl/mips_id_defines.svh ====
`ifndef MIPS_ID_DEFINES_SVH
`define MIPS_ID_DEFINES_SVH

`define MIPS_XLEN   32
`define MIPS_REG_AW 5
`define MIPS_NREGS  32
`define MIPS_RA_REG 5'd31          // Link register for JAL and BxxZAL
`define ALU_OP_W    12

// Primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// SPECIAL funct field
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// REGIMM rt selectors
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

`endif
